// ==== src/UsiPkg.sv ====
`default_nettype none

//--------------------------------------------------------------------------
// USI CSR bus geometry and block map
//--------------------------------------------------------------------------
package UsiPkg;

	localparam int lpUsiBusWidth     = 32;	// Data and address width
	localparam int lpCsrAdrsWidth    = 16;	// CSR offset, adrs[15:0]
	localparam int lpBlockAdrsWidth  = 3;	// Block field above the offset
	localparam int lpBlockConnectNum = 8;	// Slots on the read vector

	// Block field position inside adrs
	localparam int lpBlockLsb = lpCsrAdrsWidth;
	localparam int lpBlockMsb = lpCsrAdrsWidth + lpBlockAdrsWidth - 1;

	// Block map, unused slots read as zero
	localparam logic [lpBlockAdrsWidth-1:0] lpGpioAdrsMap     = 3'd0;
	localparam logic [lpBlockAdrsWidth-1:0] lpSysTimerAdrsMap = 3'd4;

	// AXI4-Lite to USI bridge FSM
	typedef enum logic [2:0]
	{
		Idle,		// Waiting for AW, W or AR
		Write,		// Write strobe on the bus
		WriteResp,	// bValid held
		Read,		// Address presented, read word captured
		ReadResp	// rValid held
	} tBridgeState;

endpackage

`default_nettype wire

// ==== src/BoardPkg.sv ====
`default_nettype none

//--------------------------------------------------------------------------
// GPIO and system timer register map
//--------------------------------------------------------------------------
package BoardPkg;

	localparam int lpGpioWidth = 6;		// Pins on the GPIO block

	// GPIO CSR offsets
	localparam logic [15:0] lpGpioOutOfs = 16'h0000;
	localparam logic [15:0] lpGpioDirOfs = 16'h0004;
	localparam logic [15:0] lpGpioAltOfs = 16'h0008;
	localparam logic [15:0] lpGpioInOfs  = 16'h000C;	// Read only

	// Timer CSR offsets
	localparam logic [15:0] lpTmrCtrlOfs     = 16'h0000;	// Bit 0 enable
	localparam logic [15:0] lpTmrPrescaleOfs = 16'h0004;
	localparam logic [15:0] lpTmrCountOfs    = 16'h0008;
	localparam logic [15:0] lpTmrCompareOfs  = 16'h000C;
	localparam logic [15:0] lpTmrStatusOfs   = 16'h0010;	// Bit 0 match, W1C

	localparam int lpPrescaleWidth = 16;

	// Heartbeat period in iMCLK cycles
	localparam int lpHeartbeatDivDefault = 25000000;

endpackage

`default_nettype wire

// ==== src/UsiBusIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface UsiBusIf
	import UsiPkg::*;
();

	logic [lpUsiBusWidth-1:0] adrs;		// Block field and CSR offset
	logic [lpUsiBusWidth-1:0] wd;		// Write data
	logic                     wr;		// One-cycle write strobe

	// One read word per block slot
	logic [lpUsiBusWidth-1:0] rdVec [lpBlockConnectNum];

	// Slots without a block return zero
	for (genvar i = 0; i < lpBlockConnectNum; i++)
	begin : gSlot
		if (i != lpGpioAdrsMap && i != lpSysTimerAdrsMap)
		begin : gEmpty
			assign rdVec[i] = '0;
		end
	end

	modport master
	(
		output adrs, wd, wr,
		input  rdVec
	);

	modport slave
	(
		input  adrs, wd, wr,
		output rdVec
	);

endinterface

`default_nettype wire

// ==== src/ResetRelease.sv ====
`timescale 1ns/1ps
`default_nettype none

module ResetRelease
(
	input  logic iMCLK,
	input  logic qnARST,	// Board reset, async
	output logic rstN		// Internal reset, released on iMCLK
);

	logic syncStage;	// First flop, may go metastable

	// Assert at once, release two edges later
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			syncStage <= 1'b0;
			rstN      <= 1'b0;
		end
		else
		begin
			syncStage <= 1'b1;
			rstN      <= syncStage;	// Second stage
		end
	end

endmodule

`default_nettype wire

// ==== src/AxiLiteUsiBridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module AxiLiteUsiBridge
	import UsiPkg::*;
(
	input  logic                       iMCLK,
	input  logic                       rstN,
	// Write address
	input  logic [lpUsiBusWidth-1:0]   awAddr,
	input  logic                       awValid,
	output logic                       awReady,
	// Write data, full-word registers only so strobes carry no meaning
	input  logic [lpUsiBusWidth-1:0]   wData,
	input  logic [lpUsiBusWidth/8-1:0] wStrb,
	input  logic                       wValid,
	output logic                       wReady,
	// Write response
	output logic [1:0]                 bResp,
	output logic                       bValid,
	input  logic                       bReady,
	// Read address
	input  logic [lpUsiBusWidth-1:0]   arAddr,
	input  logic                       arValid,
	output logic                       arReady,
	// Read data
	output logic [lpUsiBusWidth-1:0]   rData,
	output logic [1:0]                 rResp,
	output logic                       rValid,
	input  logic                       rReady,
	// CSR bus
	UsiBusIf.master                    usi
);

	tBridgeState state;
	logic        awHeld, wHeld;		// AW / W half already taken
	logic        awTake, wTake, arTake;
	logic [lpUsiBusWidth-1:0] adrsReg, wdReg, rdReg;

	//----------------------------------------------------------------------------
	// Handshakes
	//----------------------------------------------------------------------------
	assign awReady = (state == Idle) && !awHeld;
	assign wReady  = (state == Idle) && !wHeld;
	// Reads wait for any write half, write wins a tie
	assign arReady = (state == Idle) && !awHeld && !wHeld && !awValid && !wValid;

	assign awTake = awValid && awReady;
	assign wTake  = wValid && wReady;
	assign arTake = arValid && arReady;

	assign bValid = (state == WriteResp);
	assign rValid = (state == ReadResp);
	assign bResp  = 2'b00;		// OKAY
	assign rResp  = 2'b00;		// OKAY
	assign rData  = rdReg;

	assign usi.adrs = adrsReg;
	assign usi.wd   = wdReg;
	assign usi.wr   = (state == Write);	// Exactly one cycle per write

	always_ff @(posedge iMCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			state  <= Idle;
			awHeld <= 1'b0;
			wHeld  <= 1'b0;
		end
		else
		begin
			case (state)
				Idle:
				begin
					if ((awHeld || awTake) && (wHeld || wTake))
					begin
						state  <= Write;		// Both halves in hand
						awHeld <= 1'b0;
						wHeld  <= 1'b0;
					end
					else
					begin
						awHeld <= awHeld || awTake;
						wHeld  <= wHeld || wTake;
						if (arTake)
							state <= Read;
					end
				end
				Write:     state <= WriteResp;
				WriteResp: if (bReady) state <= Idle;
				Read:      state <= ReadResp;
				ReadResp:  if (rReady) state <= Idle;
				default:   state <= Idle;
			endcase
		end
	end

	// Address, write word and read word
	always_ff @(posedge iMCLK)
	begin
		if (awTake)
			adrsReg <= awAddr;
		else if (arTake)
			adrsReg <= arAddr;
		if (wTake)
			wdReg <= wData;
		if (state == Read)
			rdReg <= usi.rdVec[adrsReg[lpBlockMsb:lpBlockLsb]];	// Slot by block field
	end

endmodule

`default_nettype wire

// ==== src/GpioBlock.sv ====
`timescale 1ns/1ps
`default_nettype none

module GpioBlock
	import UsiPkg::*, BoardPkg::*;
(
	input  logic                   iMCLK,
	input  logic                   rstN,
	UsiBusIf.slave                 usi,
	input  logic                   heartbeat,	// One-cycle pulse
	input  logic                   timerMatch,
	input  logic [lpGpioWidth-1:0] gpioIn,
	output logic [lpGpioWidth-1:0] gpioOut,
	output logic [lpGpioWidth-1:0] gpioOe
);

	logic [lpGpioWidth-1:0]    outReg, dirReg, altReg;
	logic [lpGpioWidth-1:0]    inMeta, inSync;		// Two-stage input sync
	logic [lpGpioWidth-1:0]    altSrc;
	logic                      heartbeatToggle;
	logic                      blockSel;
	logic [lpCsrAdrsWidth-1:0] csrOfs;
	logic [lpUsiBusWidth-1:0]  rdData;

	assign blockSel = (usi.adrs[lpBlockMsb:lpBlockLsb] == lpGpioAdrsMap);
	assign csrOfs   = usi.adrs[lpCsrAdrsWidth-1:0];

	always_ff @(posedge iMCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			outReg          <= '0;
			dirReg          <= '0;		// All pins input
			altReg          <= '0;
			inMeta          <= '0;
			inSync          <= '0;
			heartbeatToggle <= 1'b0;
		end
		else
		begin
			inMeta <= gpioIn;
			inSync <= inMeta;
			if (heartbeat)
				heartbeatToggle <= !heartbeatToggle;
			if (usi.wr && blockSel)
			begin
				case (csrOfs)
					lpGpioOutOfs: outReg <= usi.wd[lpGpioWidth-1:0];
					lpGpioDirOfs: dirReg <= usi.wd[lpGpioWidth-1:0];
					lpGpioAltOfs: altReg <= usi.wd[lpGpioWidth-1:0];
					default:      ;	// IN is read only
				endcase
			end
		end
	end

	// CSR read word
	always_comb
	begin
		rdData = '0;
		case (csrOfs)
			lpGpioOutOfs: rdData[lpGpioWidth-1:0] = outReg;
			lpGpioDirOfs: rdData[lpGpioWidth-1:0] = dirReg;
			lpGpioAltOfs: rdData[lpGpioWidth-1:0] = altReg;
			lpGpioInOfs:  rdData[lpGpioWidth-1:0] = inSync;
			default:      rdData = '0;
		endcase
	end

	assign usi.rdVec[lpGpioAdrsMap] = rdData;

	// Alternate sources, even pins heartbeat and odd pins timer match
	always_comb
	begin
		for (int i = 0; i < lpGpioWidth; i++)
			altSrc[i] = (i % 2 == 1) ? timerMatch : heartbeatToggle;
	end

	assign gpioOut = (outReg & ~altReg) | (altSrc & altReg);
	assign gpioOe  = dirReg | altReg;		// ALT forces drive

endmodule

`default_nettype wire

// ==== src/SysTimerBlock.sv ====
`timescale 1ns/1ps
`default_nettype none

module SysTimerBlock
	import UsiPkg::*, BoardPkg::*;
(
	input  logic   iMCLK,
	input  logic   rstN,
	UsiBusIf.slave usi,
	output logic   timerMatch		// Sticky match flag
);

	logic                       enableReg;
	logic [lpPrescaleWidth-1:0] prescaleReg;
	logic [lpPrescaleWidth-1:0] prescaleCnt;
	logic [lpUsiBusWidth-1:0]   countReg;
	logic [lpUsiBusWidth-1:0]   compareReg;
	logic                       matchFlag;
	logic                       tick;		// Counter advance
	logic                       blockSel;
	logic                       csrWr;
	logic [lpCsrAdrsWidth-1:0]  csrOfs;
	logic [lpUsiBusWidth-1:0]   rdData;

	assign blockSel = (usi.adrs[lpBlockMsb:lpBlockLsb] == lpSysTimerAdrsMap);
	assign csrOfs   = usi.adrs[lpCsrAdrsWidth-1:0];
	assign csrWr    = usi.wr && blockSel;

	// One tick every PRESCALE+1 cycles
	assign tick = enableReg && (prescaleCnt == prescaleReg);

	//----------------------------------------------------------------------------
	// Prescaler, counter and match
	//----------------------------------------------------------------------------
	always_ff @(posedge iMCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			enableReg   <= 1'b0;
			prescaleReg <= '0;
			prescaleCnt <= '0;
			countReg    <= '0;
			compareReg  <= '0;
			matchFlag   <= 1'b0;
		end
		else
		begin
			if (!enableReg || tick)
				prescaleCnt <= '0;
			else
				prescaleCnt <= prescaleCnt + 1'b1;

			// CSR preset beats the tick
			if (csrWr && csrOfs == lpTmrCountOfs)
				countReg <= usi.wd;
			else if (tick)
				countReg <= countReg + 1'b1;

			// A match in the clear cycle is kept
			if (enableReg && countReg == compareReg)
				matchFlag <= 1'b1;
			else if (csrWr && csrOfs == lpTmrStatusOfs && usi.wd[0])
				matchFlag <= 1'b0;	// Write 1 to clear

			if (csrWr)
			begin
				case (csrOfs)
					lpTmrCtrlOfs:     enableReg   <= usi.wd[0];
					lpTmrPrescaleOfs: prescaleReg <= usi.wd[lpPrescaleWidth-1:0];
					lpTmrCompareOfs:  compareReg  <= usi.wd;
					default:          ;	// COUNT and STATUS above
				endcase
			end
		end
	end

	// CSR read word
	always_comb
	begin
		rdData = '0;
		case (csrOfs)
			lpTmrCtrlOfs:     rdData[0] = enableReg;
			lpTmrPrescaleOfs: rdData[lpPrescaleWidth-1:0] = prescaleReg;
			lpTmrCountOfs:    rdData = countReg;
			lpTmrCompareOfs:  rdData = compareReg;
			lpTmrStatusOfs:   rdData[0] = matchFlag;
			default:          rdData = '0;
		endcase
	end

	assign usi.rdVec[lpSysTimerAdrsMap] = rdData;
	assign timerMatch = matchFlag;

endmodule

`default_nettype wire

// ==== src/PulseGenerator.sv ====
`timescale 1ns/1ps
`default_nettype none

module PulseGenerator
#(
	parameter int pDivCount = 2		// Period in cycles, 2 or more
)
(
	input  logic iMCLK,
	input  logic rstN,
	output logic pulse		// High for one cycle per period
);

	logic [$clog2(pDivCount)-1:0] divCnt;

	// Reload is pDivCount-1, the low bits wrap for a power of two
	always_ff @(posedge iMCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			divCnt <= pDivCount[$clog2(pDivCount)-1:0] - 1'b1;
			pulse  <= 1'b0;
		end
		else if (divCnt == '0)
		begin
			divCnt <= pDivCount[$clog2(pDivCount)-1:0] - 1'b1;
			pulse  <= 1'b1;
		end
		else
		begin
			divCnt <= divCnt - 1'b1;
			pulse  <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== src/BoardCtrlTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module BoardCtrlTop
	import UsiPkg::*, BoardPkg::*;
#(
	parameter int pHeartbeatDiv = lpHeartbeatDivDefault
)
(
	input  logic                       iMCLK,
	input  logic                       qnARST,
	// AXI4-Lite slave
	input  logic [lpUsiBusWidth-1:0]   awAddr,
	input  logic                       awValid,
	output logic                       awReady,
	input  logic [lpUsiBusWidth-1:0]   wData,
	input  logic [lpUsiBusWidth/8-1:0] wStrb,
	input  logic                       wValid,
	output logic                       wReady,
	output logic [1:0]                 bResp,
	output logic                       bValid,
	input  logic                       bReady,
	input  logic [lpUsiBusWidth-1:0]   arAddr,
	input  logic                       arValid,
	output logic                       arReady,
	output logic [lpUsiBusWidth-1:0]   rData,
	output logic [1:0]                 rResp,
	output logic                       rValid,
	input  logic                       rReady,
	// GPIO pins
	output logic [lpGpioWidth-1:0]     gpioOut,
	output logic [lpGpioWidth-1:0]     gpioOe,
	input  logic [lpGpioWidth-1:0]     gpioIn
);

	logic rstN;
	logic heartbeat;
	logic timerMatch;

	UsiBusIf usiBus ();

	ResetRelease ResetRelease_inst (.iMCLK(iMCLK), .qnARST(qnARST), .rstN(rstN));

	AxiLiteUsiBridge AxiLiteUsiBridge_inst
	(
		.iMCLK(iMCLK),		.rstN(rstN),
		.awAddr(awAddr),	.awValid(awValid),	.awReady(awReady),
		.wData(wData),		.wStrb(wStrb),		.wValid(wValid),	.wReady(wReady),
		.bResp(bResp),		.bValid(bValid),	.bReady(bReady),
		.arAddr(arAddr),	.arValid(arValid),	.arReady(arReady),
		.rData(rData),		.rResp(rResp),		.rValid(rValid),	.rReady(rReady),
		.usi(usiBus.master)
	);

	GpioBlock GpioBlock_inst
	(
		.iMCLK(iMCLK),			.rstN(rstN),		.usi(usiBus.slave),
		.heartbeat(heartbeat),	.timerMatch(timerMatch),
		.gpioIn(gpioIn),		.gpioOut(gpioOut),	.gpioOe(gpioOe)
	);

	SysTimerBlock SysTimerBlock_inst
	(
		.iMCLK(iMCLK),	.rstN(rstN),	.usi(usiBus.slave),	.timerMatch(timerMatch)
	);

	// Heartbeat for the GPIO alternate mode
	PulseGenerator #(.pDivCount(pHeartbeatDiv)) PulseGenerator_inst
	(
		.iMCLK(iMCLK),	.rstN(rstN),	.pulse(heartbeat)
	);

endmodule

`default_nettype wire

// ==== sim/TbAxiTasks.svh ====
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

//--------------------------------------------------------------------------
// AXI4-Lite master side and value compare
//--------------------------------------------------------------------------

// Stop on the first difference
task automatic checkValue(input string name, input logic [31:0] actual,
	input logic [31:0] expected);
	if (actual !== expected)
	begin
		$display("MISMATCH at %0t ns: %s is 0x%08h, expected 0x%08h",
			$time, name, actual, expected);
		$display("Test failed");
		$fatal(1);
	end
endtask

// Order 0 sends AW first, 1 sends W first, 2 sends both together
task automatic writeWord(input logic [31:0] addr, input logic [31:0] data,
	input int order, input int bDelay);
	logic awDone;
	logic wDone;
	logic awHit;
	logic wHit;
	awDone = 1'b0;
	wDone  = 1'b0;
	@(posedge iMCLK);
	awAddr  <= addr;
	wData   <= data;
	wStrb   <= 4'hF;
	awValid <= (order != 1);
	wValid  <= (order != 0);
	while (!(awDone && wDone))
	begin
		@(negedge iMCLK);
		awHit = awValid && awReady;		// Handshake on the coming edge
		wHit  = wValid && wReady;
		@(posedge iMCLK);
		awDone = awDone || awHit;
		wDone  = wDone || wHit;
		awValid <= !awDone && (order != 1 || wDone);	// Second half after the first
		wValid  <= !wDone && (order != 0 || awDone);
	end
	do
		@(negedge iMCLK);
	while (!bValid);
	checkValue("bResp", 32'(bResp), 32'd0);
	// Master stalls, response must hold
	repeat (bDelay)
	begin
		@(negedge iMCLK);
		checkValue("bValid", 32'(bValid), 32'd1);
	end
	@(posedge iMCLK);
	bReady <= 1'b1;
	@(negedge iMCLK);
	checkValue("bValid", 32'(bValid), 32'd1);
	@(posedge iMCLK);
	bReady <= 1'b0;
endtask

task automatic readWord(input logic [31:0] addr, output logic [31:0] data,
	input int rDelay);
	@(posedge iMCLK);
	arAddr  <= addr;
	arValid <= 1'b1;
	do
		@(negedge iMCLK);
	while (!arReady);
	@(posedge iMCLK);
	arValid <= 1'b0;
	do
		@(negedge iMCLK);
	while (!rValid);
	checkValue("rResp", 32'(rResp), 32'd0);
	data = rData;
	repeat (rDelay)
	begin
		@(negedge iMCLK);
		checkValue("rValid", 32'(rValid), 32'd1);
		checkValue("rData held", rData, data);
	end
	@(posedge iMCLK);
	rReady <= 1'b1;
	@(negedge iMCLK);
	checkValue("rValid", 32'(rValid), 32'd1);
	@(posedge iMCLK);
	rReady <= 1'b0;
endtask

`endif

// ==== sim/tb_BoardCtrlTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_BoardCtrlTop;

	// Register addresses, block number in bits 18:16
	localparam logic [31:0] adrGpioOut     = 32'h0000_0000;
	localparam logic [31:0] adrGpioDir     = 32'h0000_0004;
	localparam logic [31:0] adrGpioAlt     = 32'h0000_0008;
	localparam logic [31:0] adrGpioIn      = 32'h0000_000C;
	localparam logic [31:0] adrTmrCtrl     = 32'h0004_0000;
	localparam logic [31:0] adrTmrPrescale = 32'h0004_0004;
	localparam logic [31:0] adrTmrCount    = 32'h0004_0008;
	localparam logic [31:0] adrTmrCompare  = 32'h0004_000C;
	localparam logic [31:0] adrTmrStatus   = 32'h0004_0010;

	localparam logic [31:0] allRegs [9] = '{adrGpioOut, adrGpioDir, adrGpioAlt, adrGpioIn,
		adrTmrCtrl, adrTmrPrescale, adrTmrCount, adrTmrCompare, adrTmrStatus};
	localparam logic [31:0] rwRegs [4] = '{adrGpioOut, adrGpioDir, adrTmrPrescale,
		adrTmrCompare};

	localparam int estCycles  = 1500;		// Six tests, worst-case stalls
	localparam int cycleLimit = estCycles * 8 / 3;

	logic        iMCLK;
	logic        qnARST;
	logic [31:0] awAddr, wData, arAddr, rData;
	logic [3:0]  wStrb;
	logic        awValid, awReady, wValid, wReady, bValid, bReady;
	logic        arValid, arReady, rValid, rReady;
	logic [1:0]  bResp, rResp;
	logic [5:0]  gpioOut, gpioOe, gpioIn;

	// Register model, updated on each completed write
	logic [5:0]  outM      = '0;
	logic [5:0]  dirM      = '0;
	logic [5:0]  altM      = '0;
	logic [5:0]  inM       = '0;	// Last value driven on gpioIn
	logic        enM       = 1'b0;
	logic        statusM   = 1'b0;
	logic [15:0] prescaleM = '0;
	logic [31:0] countM    = '0;	// Valid only while stopped
	logic [31:0] compareM  = '0;

	logic [31:0] rdAddrQ [$];
	logic [31:0] rdDataQ [$];
	int          strobeCount;
	int          strobeExpect = 0;
	integer      seed = 32'h0b954511;

	BoardCtrlTop #(.pHeartbeatDiv(8)) BoardCtrlTop_inst (.*);

	`include "TbAxiTasks.svh"

	//----------------------------------------------------------------------------
	// Reference model
	//----------------------------------------------------------------------------
	function automatic logic [31:0] refReg(input logic [31:0] addr);
		logic [31:0] val;
		val = 32'd0;
		case (addr)
			adrGpioOut:     val = {26'd0, outM};
			adrGpioDir:     val = {26'd0, dirM};
			adrGpioAlt:     val = {26'd0, altM};
			adrGpioIn:      val = {26'd0, inM};
			adrTmrCtrl:     val = {31'd0, enM};
			adrTmrPrescale: val = {16'd0, prescaleM};
			adrTmrCount:    val = countM;
			adrTmrCompare:  val = compareM;
			adrTmrStatus:   val = {31'd0, statusM};
			default:        val = 32'd0;		// Empty slot or offset
		endcase
		return val;
	endfunction

	function automatic void updateModel(input logic [31:0] addr, input logic [31:0] data);
		case (addr)
			adrGpioOut:     outM = data[5:0];
			adrGpioDir:     dirM = data[5:0];
			adrGpioAlt:     altM = data[5:0];
			adrTmrCtrl:     enM = data[0];
			adrTmrPrescale: prescaleM = data[15:0];
			adrTmrCount:    countM = data;
			adrTmrCompare:  compareM = data;
			adrTmrStatus:   if (data[0]) statusM = 1'b0;	// W1C
			default:        ;	// IN and empty blocks ignore writes
		endcase
	endfunction

	function automatic int pickDelay();
		return $random(seed) & 7;
	endfunction

	// Any block but GPIO and timer
	function automatic logic [31:0] pickUnmapped();
		logic [2:0] blk;
		blk = 3'($random(seed));
		if (blk == 3'd0 || blk == 3'd4)
			blk = blk + 3'd1;
		return {13'd0, blk, 11'd0, 5'($random(seed)) & 5'h1C};
	endfunction

	task automatic storeReg(input logic [31:0] addr, input logic [31:0] data, input int order,
		input int bDelay);
		strobeExpect++;
		writeWord(addr, data, order, bDelay);
		checkValue("usi wr strobes", 32'(strobeCount), 32'(strobeExpect));	// Exactly one
		updateModel(addr, data);
	endtask

	task automatic queueRead(input logic [31:0] addr, input int rDelay);
		logic [31:0] data;
		readWord(addr, data, rDelay);
		rdAddrQ.push_back(addr);
		rdDataQ.push_back(data);
	endtask

	initial
	begin
		iMCLK = 1'b0;
		forever
			#4 iMCLK = ~iMCLK;		// 8 ns
	end

	// Strobes seen on the internal bus
	initial
	begin
		strobeCount = 0;
		forever
		begin
			@(negedge iMCLK);
			if (BoardCtrlTop_inst.usiBus.wr)
				strobeCount++;
		end
	end

	initial
	begin : readCompare
		logic [31:0] addr;
		logic [31:0] data;
		forever
		begin
			@(negedge iMCLK);
			while (rdAddrQ.size() > 0)
			begin
				addr = rdAddrQ.pop_front();
				data = rdDataQ.pop_front();
				checkValue($sformatf("rData @ 0x%08h", addr), data, refReg(addr));
			end
		end
	end

	initial
	begin : watchdog
		int cycleCount;
		cycleCount = 0;
		while (cycleCount < cycleLimit)
		begin
			@(posedge iMCLK);
			cycleCount++;
		end
		$display("Timeout: tests still running after %0d clock cycles", cycleLimit);
		$display("Test failed");
		$fatal(1);
	end

	//----------------------------------------------------------------------------
	// Stimulus
	//----------------------------------------------------------------------------
	initial
	begin : stimulus
		logic [31:0] data;
		logic [31:0] first;
		logic [31:0] second;
		logic [31:0] sampleA;
		logic [31:0] sampleB;
		qnARST  <= 1'b0;
		awAddr  <= '0;
		awValid <= 1'b0;
		wData   <= '0;
		wStrb   <= '0;
		wValid  <= 1'b0;
		bReady  <= 1'b0;
		arAddr  <= '0;
		arValid <= 1'b0;
		rReady  <= 1'b0;
		gpioIn  <= '0;
		repeat (5) @(posedge iMCLK);
		qnARST <= 1'b1;
		repeat (3) @(posedge iMCLK);		// Two-flop release

		// Reset values
		@(negedge iMCLK);
		checkValue("awReady", 32'(awReady), 32'd1);
		checkValue("wReady", 32'(wReady), 32'd1);
		checkValue("arReady", 32'(arReady), 32'd1);
		checkValue("bValid", 32'(bValid), 32'd0);
		checkValue("rValid", 32'(rValid), 32'd0);
		checkValue("gpioOe", 32'(gpioOe), 32'd0);
		for (int i = 0; i < 9; i++)
			queueRead(allRegs[i], 0);

		// OUT and DIR with ALT clear, then an empty block
		for (int i = 0; i < 4; i++)
		begin
			storeReg(adrGpioOut, $random(seed), 2, pickDelay());
			storeReg(adrGpioDir, $random(seed), 2, pickDelay());
			queueRead(adrGpioOut, pickDelay());
			queueRead(adrGpioDir, 0);
			@(negedge iMCLK);
			checkValue("gpioOut", 32'(gpioOut), 32'(outM));
			checkValue("gpioOe", 32'(gpioOe), 32'(dirM | altM));
			data = pickUnmapped();
			storeReg(data, $random(seed), 2, 0);
			queueRead(data, 0);
		end

		// IN through the synchronizer
		for (int i = 0; i < 4; i++)
		begin
			@(posedge iMCLK);
			data = $random(seed);
			gpioIn <= data[5:0];
			inM = data[5:0];
			repeat (3) @(posedge iMCLK);
			queueRead(adrGpioIn, 0);
		end

		// Heartbeat on even pins
		storeReg(adrGpioOut, $random(seed), 0, 0);
		storeReg(adrGpioAlt, 32'h0000_0015, 1, 0);
		@(negedge iMCLK);
		sampleA = 32'(gpioOut);
		checkValue("gpioOe", 32'(gpioOe), 32'(dirM | altM));
		checkValue("gpioOut even pins agree",
			32'((sampleA & 32'h15) == 32'h0 || (sampleA & 32'h15) == 32'h15), 32'd1);
		repeat (8) @(negedge iMCLK);		// One heartbeat period
		sampleB = 32'(gpioOut);
		checkValue("gpioOut even toggle", (sampleA ^ sampleB) & 32'h15, 32'h15);
		checkValue("gpioOut odd pins", sampleA & 32'h2A, 32'(outM) & 32'h2A);
		checkValue("gpioOut odd pins", sampleB & 32'h2A, 32'(outM) & 32'h2A);

		// Timer run, match flag on the odd pins
		storeReg(adrTmrCompare, 32'd600, 2, 0);
		storeReg(adrTmrPrescale, 32'd0, 2, 0);
		storeReg(adrGpioAlt, 32'h0000_002A, 2, 0);
		storeReg(adrTmrCtrl, 32'd1, 2, 0);
		readWord(adrTmrCount, first, 0);
		readWord(adrTmrCount, second, 0);
		checkValue("COUNT increases", 32'(second > first), 32'd1);
		storeReg(adrTmrCount, 32'd560, 2, 0);	// Preset below COMPARE
		data = 32'd0;
		while (data[0] == 1'b0)
			readWord(adrTmrStatus, data, 0);
		@(negedge iMCLK);
		checkValue("gpioOut odd pins", 32'(gpioOut) & 32'h2A, 32'h2A);
		checkValue("gpioOe", 32'(gpioOe), 32'(dirM | altM));
		storeReg(adrTmrStatus, 32'd1, 2, 0);
		queueRead(adrTmrStatus, 0);
		@(negedge iMCLK);
		checkValue("gpioOut odd pins", 32'(gpioOut) & 32'h2A, 32'h0);
		storeReg(adrTmrCtrl, 32'd0, 2, 0);
		storeReg(adrGpioAlt, 32'd0, 2, 0);

		// Channel order and response stalls
		for (int i = 0; i < 12; i++)
		begin
			storeReg(rwRegs[i % 4], $random(seed), i % 3, pickDelay());
			queueRead(rwRegs[i % 4], pickDelay());
		end

		repeat (2) @(negedge iMCLK);
		checkValue("reads left unchecked", 32'(rdAddrQ.size()), 32'd0);
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+sim
src/UsiPkg.sv
src/BoardPkg.sv
src/UsiBusIf.sv
src/ResetRelease.sv
src/AxiLiteUsiBridge.sv
src/GpioBlock.sv
src/SysTimerBlock.sv
src/PulseGenerator.sv
src/BoardCtrlTop.sv
sim/tb_BoardCtrlTop.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the board controller testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_BoardCtrlTop \
	-Mdir obj_dir -o simBoardCtrl

# The run may stop on $fatal, so keep its output for the search
output=$(./obj_dir/simBoardCtrl 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "Test passed"; then
	exit 0
fi
exit 1
